// ==== tensor_pkg.sv ====
package tensor_pkg;

    // Image and RAM geometry
    localparam int IMG_MAX_W = 16;
    localparam int IMG_MAX_H = 16;
    localparam int RAM_WORDS = IMG_MAX_W * IMG_MAX_H;
    localparam int RAM_AW    = 8;

    // 7x7 window covers a 4x4 output block with a 4x4 kernel
    localparam int WIN = 7;
    localparam int BLK = 4;

    localparam int CMD_CREDITS = 2;
    localparam int OUT_CREDITS = 4;

    typedef logic signed [7:0] int8_t;

    // Four channels of one pixel, lane 0 in the low byte
    typedef int8_t [3:0] pix_t;

    typedef enum logic [1:0] {
        OP_SET_SIZE  = 2'd0,
        OP_SET_PAD   = 2'd1,
        OP_RUN_BLOCK = 2'd2
    } cmd_op_t;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_FETCH,
        LD_DONE
    } load_state_t;

    typedef enum logic [1:0] {
        FM_IDLE,
        FM_STREAM,
        FM_RELEASE
    } fmt_state_t;

    typedef struct packed {
        logic [3:0] bx;
        logic [3:0] by;
        logic [4:0] width;
        logic [4:0] height;
        logic [1:0] pad_top;
        logic [1:0] pad_left;
    } job_t;

endpackage

// ==== window_if.sv ====
`timescale 1ns/1ps

interface window_if
    import tensor_pkg::*;
();

    logic [1:0]           bank_full;
    logic                 rd_bank;
    logic [$clog2(WIN)-1:0] rd_row;
    logic [$clog2(WIN)-1:0] rd_col;
    pix_t [BLK-1:0]       rd_data;
    // Pulse that frees the bank selected by rd_bank
    logic                 bank_release;

    modport loader (
        output bank_full,
        output rd_data,
        input  rd_bank,
        input  rd_row,
        input  rd_col,
        input  bank_release
    );

    modport formatter (
        input  bank_full,
        input  rd_data,
        output rd_bank,
        output rd_row,
        output rd_col,
        output bank_release
    );

endinterface

// ==== tensor_ram.sv ====
`timescale 1ns/1ps

module tensor_ram
    import tensor_pkg::*;
(
    input  logic              clk,
    input  logic              we,
    input  logic [RAM_AW-1:0] waddr,
    input  pix_t              wdata,
    input  logic              re,
    input  logic [RAM_AW-1:0] raddr,
    output pix_t              rdata
);

    // One word per pixel, y * IMG_MAX_W + x
    pix_t mem [RAM_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read data valid the cycle after re
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== block_cmd_decoder.sv ====
`timescale 1ns/1ps

module block_cmd_decoder
    import tensor_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cmd_valid,
    input  cmd_op_t     cmd_op,
    input  logic [15:0] cmd_arg,
    output logic        cmd_credit,
    output logic        job_valid,
    input  logic        job_ready,
    output job_t        job
);

    cmd_op_t     q_op  [CMD_CREDITS];
    logic [15:0] q_arg [CMD_CREDITS];

    logic [$clog2(CMD_CREDITS)-1:0]   wr_ptr;
    logic [$clog2(CMD_CREDITS)-1:0]   rd_ptr;
    logic [$clog2(CMD_CREDITS+1)-1:0] count;

    logic [4:0] cfg_width;
    logic [4:0] cfg_height;
    logic [1:0] cfg_pad_top;
    logic [1:0] cfg_pad_left;

    logic head_valid;
    logic head_is_run;
    logic pop;

    assign head_valid  = (count != '0);
    assign head_is_run = (q_op[rd_ptr] == OP_RUN_BLOCK);
    assign job_valid   = head_valid && head_is_run;

    // Config commands leave at once, a block waits for the loader
    assign pop        = head_valid && (!head_is_run || job_ready);
    assign cmd_credit = pop;

    always_comb begin
        job.bx       = q_arg[rd_ptr][3:0];
        job.by       = q_arg[rd_ptr][7:4];
        job.width    = cfg_width;
        job.height   = cfg_height;
        job.pad_top  = cfg_pad_top;
        job.pad_left = cfg_pad_left;
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            q_op[wr_ptr]  <= cmd_op;
            q_arg[wr_ptr] <= cmd_arg;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            cfg_width    <= 5'(IMG_MAX_W);
            cfg_height   <= 5'(IMG_MAX_H);
            cfg_pad_top  <= '0;
            cfg_pad_left <= '0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= (wr_ptr == CMD_CREDITS - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == CMD_CREDITS - 1) ? '0 : rd_ptr + 1'b1;
                if (q_op[rd_ptr] == OP_SET_SIZE) begin
                    cfg_width  <= q_arg[rd_ptr][4:0];
                    cfg_height <= q_arg[rd_ptr][12:8];
                end else if (q_op[rd_ptr] == OP_SET_PAD) begin
                    cfg_pad_top  <= q_arg[rd_ptr][1:0];
                    cfg_pad_left <= q_arg[rd_ptr][3:2];
                end
            end
            case ({cmd_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== window_loader.sv ====
`timescale 1ns/1ps

module window_loader
    import tensor_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              job_valid,
    output logic              job_ready,
    input  job_t              job,
    output logic              ram_re,
    output logic [RAM_AW-1:0] ram_raddr,
    input  pix_t              ram_rdata,
    window_if.loader          win
);

    load_state_t state;
    job_t        job_q;
    logic        wr_bank;
    logic [1:0]  bank_full;
    logic [1:0]  set_full;
    logic [1:0]  clr_full;

    logic [$clog2(WIN)-1:0] wx;
    logic [$clog2(WIN)-1:0] wy;
    logic signed [7:0]      img_x;
    logic signed [7:0]      img_y;
    logic                   in_bounds;
    logic                   last_pix;

    // Write stage, one cycle behind the read request
    logic                   s1_valid;
    logic                   s1_inb;
    logic [$clog2(WIN)-1:0] s1_wx;
    logic [$clog2(WIN)-1:0] s1_wy;

    pix_t bank_mem [2][WIN][WIN];

    assign job_ready = (state == LD_IDLE) && !bank_full[wr_bank];

    // Window origin is (bx*4 - pad_left, by*4 - pad_top)
    assign img_x = 8'(job_q.bx * BLK) - 8'(job_q.pad_left) + 8'(wx);
    assign img_y = 8'(job_q.by * BLK) - 8'(job_q.pad_top) + 8'(wy);

    assign in_bounds = (img_x >= 0) && (img_x < $signed({3'b000, job_q.width}))
                    && (img_y >= 0) && (img_y < $signed({3'b000, job_q.height}));

    assign last_pix = (wx == WIN - 1) && (wy == WIN - 1);

    // Padding pixels skip the RAM
    assign ram_re    = (state == LD_FETCH) && in_bounds;
    assign ram_raddr = RAM_AW'(img_y * IMG_MAX_W + img_x);

    assign set_full = (state == LD_DONE) ? (2'b01 << wr_bank) : 2'b00;
    assign clr_full = win.bank_release ? (2'b01 << win.rd_bank) : 2'b00;

    assign win.bank_full = bank_full;

    always_comb begin
        for (int j = 0; j < BLK; j++) begin
            win.rd_data[j] = bank_mem[win.rd_bank][win.rd_row][win.rd_col + 3'(j)];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= LD_IDLE;
            wr_bank   <= 1'b0;
            bank_full <= 2'b00;
            wx        <= '0;
            wy        <= '0;
            s1_valid  <= 1'b0;
        end else begin
            s1_valid  <= (state == LD_FETCH);
            bank_full <= (bank_full | set_full) & ~clr_full;
            case (state)
                LD_IDLE: begin
                    if (job_valid && job_ready) begin
                        wx    <= '0;
                        wy    <= '0;
                        state <= LD_FETCH;
                    end
                end
                LD_FETCH: begin
                    if (wx == WIN - 1) begin
                        wx <= '0;
                        wy <= wy + 1'b1;
                    end else begin
                        wx <= wx + 1'b1;
                    end
                    if (last_pix) begin
                        state <= LD_DONE;
                    end
                end
                LD_DONE: begin
                    // Last word lands this cycle
                    wr_bank <= ~wr_bank;
                    state   <= LD_IDLE;
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (job_valid && job_ready) begin
            job_q <= job;
        end
        s1_inb <= in_bounds;
        s1_wx  <= wx;
        s1_wy  <= wy;
        if (s1_valid) begin
            bank_mem[wr_bank][s1_wy][s1_wx] <= s1_inb ? ram_rdata : '0;
        end
    end

endmodule

// ==== patch_formatter.sv ====
`timescale 1ns/1ps

module patch_formatter
    import tensor_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    window_if.formatter  win,
    output logic         out_valid,
    output pix_t         out_a0,
    output pix_t         out_a1,
    output pix_t         out_a2,
    output pix_t         out_a3,
    output logic         out_last,
    input  logic         out_credit
);

    fmt_state_t state;
    logic       cur_bank;

    // Beat index is {r, ky, kx}, r outermost
    logic [5:0] beat;
    logic [1:0] r;
    logic [1:0] ky;
    logic [1:0] kx;

    logic [$clog2(OUT_CREDITS+1)-1:0] credits;
    logic fire;
    logic last_beat;

    assign r  = beat[5:4];
    assign ky = beat[3:2];
    assign kx = beat[1:0];

    assign win.rd_bank      = cur_bank;
    assign win.rd_row       = {1'b0, r} + {1'b0, ky};
    assign win.rd_col       = {1'b0, kx};
    assign win.bank_release = (state == FM_RELEASE);

    assign fire      = (state == FM_STREAM) && (credits != '0);
    assign last_beat = (beat == 6'(BLK * BLK * BLK - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= FM_IDLE;
            cur_bank  <= 1'b0;
            beat      <= '0;
            credits   <= ($clog2(OUT_CREDITS+1))'(OUT_CREDITS);
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= fire;
            out_last  <= fire && last_beat;
            case ({fire, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            case (state)
                FM_IDLE: begin
                    if (win.bank_full[cur_bank]) begin
                        beat  <= '0;
                        state <= FM_STREAM;
                    end
                end
                FM_STREAM: begin
                    // Hold position while out of credits
                    if (fire) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state <= FM_RELEASE;
                        end
                    end
                end
                FM_RELEASE: begin
                    cur_bank <= ~cur_bank;
                    state    <= FM_IDLE;
                end
                default: state <= FM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_a0 <= win.rd_data[0];
            out_a1 <= win.rd_data[1];
            out_a2 <= win.rd_data[2];
            out_a3 <= win.rd_data[3];
        end
    end

endmodule

// ==== conv_frontend_top.sv ====
`timescale 1ns/1ps

module conv_frontend_top
    import tensor_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              cmd_valid,
    input  cmd_op_t           cmd_op,
    input  logic [15:0]       cmd_arg,
    output logic              cmd_credit,

    input  logic              ram_we,
    input  logic [RAM_AW-1:0] ram_waddr,
    input  pix_t              ram_wdata,

    output logic              out_valid,
    output pix_t              out_a0,
    output pix_t              out_a1,
    output pix_t              out_a2,
    output pix_t              out_a3,
    output logic              out_last,
    input  logic              out_credit
);

    logic              job_valid;
    logic              job_ready;
    job_t              job;
    logic              ram_re;
    logic [RAM_AW-1:0] ram_raddr;
    pix_t              ram_rdata;

    window_if win_if ();

    tensor_ram tensor_ram_i (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .re    (ram_re),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    block_cmd_decoder block_cmd_decoder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_arg    (cmd_arg),
        .cmd_credit (cmd_credit),
        .job_valid  (job_valid),
        .job_ready  (job_ready),
        .job        (job)
    );

    window_loader window_loader_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .job_valid (job_valid),
        .job_ready (job_ready),
        .job       (job),
        .ram_re    (ram_re),
        .ram_raddr (ram_raddr),
        .ram_rdata (ram_rdata),
        .win       (win_if.loader)
    );

    patch_formatter patch_formatter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .win        (win_if.formatter),
        .out_valid  (out_valid),
        .out_a0     (out_a0),
        .out_a1     (out_a1),
        .out_a2     (out_a2),
        .out_a3     (out_a3),
        .out_last   (out_last),
        .out_credit (out_credit)
    );

endmodule

// ==== tb_conv_frontend.sv ====
`timescale 1ns/1ps

module tb_conv_frontend
    import tensor_pkg::*;
();

    logic              clk = 1'b0;
    logic              rst_n;
    logic              cmd_valid;
    cmd_op_t           cmd_op;
    logic [15:0]       cmd_arg;
    logic              cmd_credit;
    logic              ram_we;
    logic [RAM_AW-1:0] ram_waddr;
    pix_t              ram_wdata;
    logic              out_valid;
    pix_t              out_a0;
    pix_t              out_a1;
    pix_t              out_a2;
    pix_t              out_a3;
    logic              out_last;
    logic              out_credit;

    int   seed;
    pix_t image [RAM_WORDS];
    int   cfg_width = IMG_MAX_W;
    int   cfg_height = IMG_MAX_H;
    int   cfg_pad_top = 0;
    int   cfg_pad_left = 0;

    pix_t [BLK-1:0] exp_beats [$];
    logic           exp_last [$];
    pix_t [BLK-1:0] cur_beat;
    logic           cur_last;

    int   cmd_credits_held = CMD_CREDITS;
    int   out_credits_held = OUT_CREDITS;
    int   credit_pulses = 0;
    int   cmds_sent = 0;
    int   beats_seen = 0;
    logic hold_credits = 1'b0;

    conv_frontend_top conv_frontend_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_arg    (cmd_arg),
        .cmd_credit (cmd_credit),
        .ram_we     (ram_we),
        .ram_waddr  (ram_waddr),
        .ram_wdata  (ram_wdata),
        .out_valid  (out_valid),
        .out_a0     (out_a0),
        .out_a1     (out_a1),
        .out_a2     (out_a2),
        .out_a3     (out_a3),
        .out_last   (out_last),
        .out_credit (out_credit)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic fail_with(input string why);
        $display("%s at %0t ns", why, $time);
        abort_run();
    endtask

    task automatic check_pix(input string name, input pix_t expected, input pix_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %h got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %b got %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERROR at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // Window pixel (r+ky, kx+j) mapped back to the image, zero outside it
    function automatic pix_t ref_pixel(input int bx, input int by, input int r,
                                       input int ky, input int kx, input int j);
        int x;
        int y;
        x = bx * BLK - cfg_pad_left + kx + j;
        y = by * BLK - cfg_pad_top + r + ky;
        if (x < 0 || y < 0 || x >= cfg_width || y >= cfg_height) begin
            return '0;
        end
        return image[y * IMG_MAX_W + x];
    endfunction

    task automatic queue_block(input int bx, input int by);
        pix_t [BLK-1:0] beat;
        for (int r = 0; r < BLK; r++) begin
            for (int ky = 0; ky < BLK; ky++) begin
                for (int kx = 0; kx < BLK; kx++) begin
                    for (int j = 0; j < BLK; j++) begin
                        beat[j] = ref_pixel(bx, by, r, ky, kx, j);
                    end
                    exp_beats.push_back(beat);
                    exp_last.push_back(r == BLK - 1 && ky == BLK - 1 && kx == BLK - 1);
                end
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_cmd(input cmd_op_t op, input logic [15:0] arg);
        int waited;
        waited = 0;
        while (cmd_credits_held == 0) begin
            next_cycle();
            waited++;
            if (waited > 2000) fail_with("Timed out waiting for a command credit");
        end
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_arg   = arg;
        cmd_credits_held--;
        cmds_sent++;
        next_cycle();
        cmd_valid = 1'b0;
    endtask

    task automatic set_size(input int w, input int h);
        cfg_width  = w;
        cfg_height = h;
        send_cmd(OP_SET_SIZE, {8'(h), 8'(w)});
    endtask

    task automatic set_pad(input int top, input int left);
        cfg_pad_top  = top;
        cfg_pad_left = left;
        send_cmd(OP_SET_PAD, 16'(left * 4 + top));
    endtask

    task automatic run_block(input int bx, input int by);
        queue_block(bx, by);
        send_cmd(OP_RUN_BLOCK, 16'(by * 16 + bx));
    endtask

    task automatic write_image();
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_we    = 1'b1;
            ram_waddr = RAM_AW'(i);
            ram_wdata = image[i];
            next_cycle();
        end
        ram_we = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_beats.size() != 0 || out_credits_held != OUT_CREDITS) begin
            next_cycle();
            waited++;
            if (waited > 5000) fail_with("Timed out waiting for blocks to drain");
        end
    endtask

    // Downstream holds its credits, then gets them back
    task automatic check_credit_stall();
        int waited;
        int start_beats;
        waited = 0;
        hold_credits = 1'b1;
        start_beats = beats_seen;
        run_block(2, 1);
        while (beats_seen - start_beats < OUT_CREDITS) begin
            next_cycle();
            waited++;
            if (waited > 500) fail_with("Timed out waiting for the first beats");
        end
        repeat (100) next_cycle();
        check_count("beats without returned credit", OUT_CREDITS, beats_seen - start_beats);
        hold_credits = 1'b0;
        wait_drain();
    endtask

    // Downstream array returns one credit at random intervals
    initial begin
        out_credit = 1'b0;
        forever begin
            next_cycle();
            out_credit = 1'b0;
            if (rst_n && !hold_credits && out_credits_held < OUT_CREDITS
                && ($random(seed) & 3) == 0) begin
                out_credit = 1'b1;
                out_credits_held++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && cmd_credit) begin
            cmd_credits_held++;
            credit_pulses++;
        end
    end

    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            beats_seen++;
            out_credits_held--;
            if (out_credits_held < 0) begin
                fail_with("Beat emitted with no output credit held");
            end else if (exp_beats.size() == 0) begin
                fail_with("Beat emitted with no block outstanding");
            end else begin
                cur_beat = exp_beats.pop_front();
                cur_last = exp_last.pop_front();
                check_pix("out_a0", cur_beat[0], out_a0);
                check_pix("out_a1", cur_beat[1], out_a1);
                check_pix("out_a2", cur_beat[2], out_a2);
                check_pix("out_a3", cur_beat[3], out_a3);
                check_bit("out_last", cur_last, out_last);
            end
        end else if (rst_n) begin
            check_bit("out_last", 1'b0, out_last);
        end
    end

    initial begin
        seed = 32'h096a_fb24;
        // Odd lanes keep image data apart from padding zeros
        for (int i = 0; i < RAM_WORDS; i++) begin
            image[i] = $random(seed) | 32'h0101_0101;
        end
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = OP_SET_SIZE;
        cmd_arg   = '0;
        ram_we    = 1'b0;
        ram_waddr = '0;
        ram_wdata = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        write_image();

        // Interior block on the reset configuration
        run_block(1, 1);
        wait_drain();

        // Top-left corner fully padded
        set_pad(3, 3);
        run_block(0, 0);
        wait_drain();

        // Bottom-right edge of a 10x9 image
        set_size(10, 9);
        set_pad(0, 0);
        run_block(2, 2);
        wait_drain();

        set_size(16, 16);
        check_credit_stall();

        // Six blocks back to back
        set_pad(1, 2);
        run_block(0, 0);
        run_block(1, 0);
        run_block(2, 0);
        run_block(3, 0);
        run_block(0, 1);
        run_block(3, 3);
        wait_drain();

        // Config changes queued between blocks
        set_pad(0, 0);
        run_block(1, 1);
        set_pad(2, 1);
        run_block(1, 2);
        set_size(12, 11);
        run_block(2, 2);
        wait_drain();

        check_count("cmd_credit pulses", cmds_sent, credit_pulses);
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== compile.f ====
tensor_pkg.sv
window_if.sv
tensor_ram.sv
block_cmd_decoder.sv
window_loader.sv
patch_formatter.sv
conv_frontend_top.sv
tb_conv_frontend.sv
